// ==== src/scpad_pkg.sv ====
package scpad_pkg;

    // geometry of the scratchpad
    // four banks, one per lane of a word
    localparam int NUM_BANKS     = 4;
    localparam int LANE_W        = 16;
    localparam int ROWS          = 16;
    localparam int ROW_W         = $clog2(ROWS);
    localparam int SHIFT_W       = $clog2(NUM_BANKS);

    // dram ids, one queue slot per id
    localparam int DRAM_ID_WIDTH = 3;
    localparam int NUM_IDS       = 1 << DRAM_ID_WIDTH;

    typedef logic [ROW_W-1:0]   row_addr_t;
    typedef logic [SHIFT_W-1:0] lane_shift_t;

    // crossbar descriptor: base row plus lane rotation
    typedef struct packed {
        row_addr_t   row;
        lane_shift_t shift;
    } xbar_desc_t;

    // one word is four 16-bit lanes, lane 0 in the low bits
    typedef logic [NUM_BANKS-1:0][LANE_W-1:0] scpad_data_t;

    typedef enum logic {
        LAYOUT_ROW,
        LAYOUT_COL
    } layout_e;

    // backend write request, oldest completion from the queue
    typedef struct packed {
        logic        valid;
        layout_e     row_or_col;
        xbar_desc_t  xbar;
        scpad_data_t wdata;
    } sram_write_req_t;

    // single sram access, read or write
    typedef struct packed {
        logic        write;
        layout_e     row_or_col;
        xbar_desc_t  xbar;
        scpad_data_t wdata;
    } sram_access_t;

    typedef enum logic [1:0] {
        PORT_IDLE,
        PORT_WAIT_GRANT,
        PORT_WAIT_READ
    } port_state_e;

    typedef enum logic {
        REQ_BACKEND,
        REQ_FRONTEND
    } requester_e;

endpackage

// ==== src/sram_write_request_queue.sv ====
module sram_write_request_queue (
    input  logic                                 clk,
    input  logic                                 n_rst,
    input  logic                                 dr_complete,
    input  logic [scpad_pkg::DRAM_ID_WIDTH-1:0]  dram_data_id,
    input  scpad_pkg::layout_e                   dr_row_or_col,
    input  scpad_pkg::xbar_desc_t                dr_xbar,
    input  scpad_pkg::scpad_data_t               dr_rdata,
    input  logic                                 be_accept,
    output scpad_pkg::sram_write_req_t           sram_write_req,
    output logic                                 sram_write_queue_full
);
    import scpad_pkg::*;

    // per-id slots, indexed directly by dram_data_id
    logic [NUM_IDS-1:0] slot_valid;
    layout_e            slot_layout [NUM_IDS];
    xbar_desc_t         slot_xbar   [NUM_IDS];
    scpad_data_t        slot_data   [NUM_IDS];

    // ring of ids in completion order
    logic [DRAM_ID_WIDTH-1:0] ring [NUM_IDS];
    logic [DRAM_ID_WIDTH-1:0] head;
    logic [DRAM_ID_WIDTH-1:0] tail;
    // one extra bit so eight held entries can be told from empty
    logic [DRAM_ID_WIDTH:0]   count;

    logic [DRAM_ID_WIDTH-1:0] head_id;
    logic                     push;
    logic                     pop;

    assign sram_write_queue_full = (count == (DRAM_ID_WIDTH+1)'(NUM_IDS));

    // a completion while full is dropped here
    assign push = dr_complete & ~sram_write_queue_full;
    // accept only retires a real request
    assign pop  = be_accept & sram_write_req.valid;

    // oldest id selects the slot presented to the arbiter
    always_comb begin
        head_id                   = ring[head];
        sram_write_req.valid      = (count != '0) & slot_valid[head_id];
        sram_write_req.row_or_col = slot_layout[head_id];
        sram_write_req.xbar       = slot_xbar[head_id];
        sram_write_req.wdata      = slot_data[head_id];
    end

    // control state: ring pointers, occupancy and slot valids
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            slot_valid <= '0;
        end else begin
            if (pop) begin
                head                <= head + 1'b1;
                slot_valid[head_id] <= 1'b0;
            end
            // set after clear, a refill of the draining id must survive
            if (push) begin
                tail                     <= tail + 1'b1;
                slot_valid[dram_data_id] <= 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // payload: latched slot contents and the id ring entries
    always_ff @(posedge clk) begin
        if (push) begin
            slot_layout[dram_data_id] <= dr_row_or_col;
            slot_xbar[dram_data_id]   <= dr_xbar;
            slot_data[dram_data_id]   <= dr_rdata;
            ring[tail]                <= dram_data_id;
        end
    end

endmodule

// ==== src/frontend_access_port.sv ====
module frontend_access_port (
    input  logic                   clk,
    input  logic                   n_rst,
    input  logic                   fe_req,
    input  logic                   fe_write,
    input  scpad_pkg::layout_e     fe_row_or_col,
    input  scpad_pkg::xbar_desc_t  fe_xbar,
    input  scpad_pkg::scpad_data_t fe_wdata,
    input  logic                   fe_grant,
    input  scpad_pkg::scpad_data_t rd_data,
    output scpad_pkg::sram_access_t fe_access,
    output logic                   fe_pending,
    output logic                   fe_busy,
    output logic                   fe_done,
    output scpad_pkg::scpad_data_t fe_rdata
);
    import scpad_pkg::*;

    port_state_e  state;
    port_state_e  next_state;
    sram_access_t pending;
    logic         done_next;

    // held request goes straight to the arbiter
    assign fe_access  = pending;
    assign fe_pending = (state == PORT_WAIT_GRANT);
    assign fe_busy    = (state != PORT_IDLE);

    always_comb begin
        next_state = state;
        done_next  = 1'b0;
        case (state)
            PORT_IDLE: begin
                if (fe_req) begin
                    next_state = PORT_WAIT_GRANT;
                end
            end
            PORT_WAIT_GRANT: begin
                if (fe_grant) begin
                    // write lands at this edge, read data shows next cycle
                    if (pending.write) begin
                        next_state = PORT_IDLE;
                        done_next  = 1'b1;
                    end else begin
                        next_state = PORT_WAIT_READ;
                    end
                end
            end
            PORT_WAIT_READ: begin
                // rd_data valid now, capture it with done
                next_state = PORT_IDLE;
                done_next  = 1'b1;
            end
            default: next_state = PORT_IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state   <= PORT_IDLE;
            fe_done <= 1'b0;
        end else begin
            state   <= next_state;
            fe_done <= done_next;
        end
    end

    // request capture and read return
    always_ff @(posedge clk) begin
        if (state == PORT_IDLE && fe_req) begin
            pending.write      <= fe_write;
            pending.row_or_col <= fe_row_or_col;
            pending.xbar       <= fe_xbar;
            pending.wdata      <= fe_wdata;
        end
        if (state == PORT_WAIT_READ) begin
            fe_rdata <= rd_data;
        end
    end

endmodule

// ==== src/scpad_arbiter.sv ====
module scpad_arbiter (
    input  logic                       clk,
    input  logic                       n_rst,
    input  scpad_pkg::sram_write_req_t sram_write_req,
    input  scpad_pkg::sram_access_t    fe_access,
    input  logic                       fe_pending,
    output logic                       be_accept,
    output logic                       fe_grant,
    output scpad_pkg::sram_access_t    sram_access,
    output logic                       sram_en
);
    import scpad_pkg::*;

    requester_e   last_grant;
    sram_access_t be_access;
    logic         be_want;

    assign be_want = sram_write_req.valid;

    // round robin on contention, otherwise whoever asks
    always_comb begin
        be_accept = 1'b0;
        fe_grant  = 1'b0;
        if (be_want && fe_pending) begin
            if (last_grant == REQ_BACKEND) begin
                fe_grant = 1'b1;
            end else begin
                be_accept = 1'b1;
            end
        end else begin
            be_accept = be_want;
            fe_grant  = fe_pending;
        end
    end

    // backend requests are always writes
    always_comb begin
        be_access.write      = 1'b1;
        be_access.row_or_col = sram_write_req.row_or_col;
        be_access.xbar       = sram_write_req.xbar;
        be_access.wdata      = sram_write_req.wdata;
    end

    assign sram_access = fe_grant ? fe_access : be_access;
    assign sram_en     = be_accept | fe_grant;

    // frontend as last winner lets the backend take the first tie
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            last_grant <= REQ_FRONTEND;
        end else if (fe_grant) begin
            last_grant <= REQ_FRONTEND;
        end else if (be_accept) begin
            last_grant <= REQ_BACKEND;
        end
    end

endmodule

// ==== src/scpad_sram.sv ====
module scpad_sram (
    input  logic                    clk,
    input  logic                    sram_en,
    input  scpad_pkg::sram_access_t sram_access,
    output scpad_pkg::scpad_data_t  rd_data
);
    import scpad_pkg::*;

    // per-bank read data before the lanes are rotated back
    scpad_data_t bank_rdata;
    logic        wr_en;
    logic        rd_en;

    assign wr_en = sram_en & sram_access.write;
    assign rd_en = sram_en & ~sram_access.write;

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        logic [LANE_W-1:0] mem [ROWS];
        lane_shift_t       lane;
        row_addr_t         addr;

        // lane i lives in bank i + shift, so this bank holds lane b - shift
        assign lane = lane_shift_t'(b) - sram_access.xbar.shift;

        // column mode skews each lane one row further, wrapping at ROWS
        always_comb begin
            addr = sram_access.xbar.row;
            if (sram_access.row_or_col == LAYOUT_COL) begin
                addr = sram_access.xbar.row + row_addr_t'(lane);
            end
        end

        always_ff @(posedge clk) begin
            if (wr_en) begin
                mem[addr] <= sram_access.wdata[lane];
            end
        end

        assign bank_rdata[b] = mem[addr];
    end

    // gather with the write mapping so lane i returns what lane i wrote
    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int i = 0; i < NUM_BANKS; i++) begin
                rd_data[i] <= bank_rdata[lane_shift_t'(i) + sram_access.xbar.shift];
            end
        end
    end

endmodule

// ==== src/scpad_backend_top.sv ====
module scpad_backend_top (
    input  logic                                clk,
    input  logic                                n_rst,
    // dram completion side
    input  logic                                dr_complete,
    input  logic [scpad_pkg::DRAM_ID_WIDTH-1:0] dram_data_id,
    input  scpad_pkg::layout_e                  dr_row_or_col,
    input  scpad_pkg::xbar_desc_t               dr_xbar,
    input  scpad_pkg::scpad_data_t              dr_rdata,
    output logic                                sram_write_queue_full,
    // compute side
    input  logic                                fe_req,
    input  logic                                fe_write,
    input  scpad_pkg::layout_e                  fe_row_or_col,
    input  scpad_pkg::xbar_desc_t               fe_xbar,
    input  scpad_pkg::scpad_data_t              fe_wdata,
    output logic                                fe_busy,
    output logic                                fe_done,
    output scpad_pkg::scpad_data_t              fe_rdata
);
    import scpad_pkg::*;

    sram_write_req_t sram_write_req;
    sram_access_t    fe_access;
    sram_access_t    sram_access;
    scpad_data_t     rd_data;
    logic            fe_pending;
    logic            be_accept;
    logic            fe_grant;
    logic            sram_en;

    sram_write_request_queue u_queue (
        .clk                   (clk),
        .n_rst                 (n_rst),
        .dr_complete           (dr_complete),
        .dram_data_id          (dram_data_id),
        .dr_row_or_col         (dr_row_or_col),
        .dr_xbar               (dr_xbar),
        .dr_rdata              (dr_rdata),
        .be_accept             (be_accept),
        .sram_write_req        (sram_write_req),
        .sram_write_queue_full (sram_write_queue_full)
    );

    frontend_access_port u_port (
        .clk           (clk),
        .n_rst         (n_rst),
        .fe_req        (fe_req),
        .fe_write      (fe_write),
        .fe_row_or_col (fe_row_or_col),
        .fe_xbar       (fe_xbar),
        .fe_wdata      (fe_wdata),
        .fe_grant      (fe_grant),
        .rd_data       (rd_data),
        .fe_access     (fe_access),
        .fe_pending    (fe_pending),
        .fe_busy       (fe_busy),
        .fe_done       (fe_done),
        .fe_rdata      (fe_rdata)
    );

    // queue and port are peers behind one arbiter
    scpad_arbiter u_arb (
        .clk            (clk),
        .n_rst          (n_rst),
        .sram_write_req (sram_write_req),
        .fe_access      (fe_access),
        .fe_pending     (fe_pending),
        .be_accept      (be_accept),
        .fe_grant       (fe_grant),
        .sram_access    (sram_access),
        .sram_en        (sram_en)
    );

    scpad_sram u_sram (
        .clk         (clk),
        .sram_en     (sram_en),
        .sram_access (sram_access),
        .rd_data     (rd_data)
    );

endmodule

// ==== sim/tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    // 4 ns period, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

endmodule

// ==== sim/scpad_sva.sv ====
module scpad_sva (
    input logic                       clk,
    input logic                       n_rst,
    input logic                       dr_complete,
    input logic                       sram_write_queue_full,
    input logic                       be_accept,
    input logic                       fe_grant,
    input scpad_pkg::sram_write_req_t sram_write_req
);
    timeunit 1ns;
    timeprecision 1ps;

    // count of fired assertions
    int fail_count = 0;

    // the source must not complete into a full queue
    a_no_complete_when_full: assert property (@(posedge clk) disable iff (!n_rst)
        !(dr_complete && sram_write_queue_full))
    else begin
        $error("dr_complete seen while the write queue is full");
        fail_count++;
    end

    // only one requester owns the sram in a cycle
    a_single_grant: assert property (@(posedge clk) disable iff (!n_rst)
        !(be_accept && fe_grant))
    else begin
        $error("be_accept and fe_grant high in the same cycle");
        fail_count++;
    end

    // queue head holds still until the arbiter takes it
    a_request_held: assert property (@(posedge clk) disable iff (!n_rst)
        (sram_write_req.valid && !be_accept) |=> $stable(sram_write_req))
    else begin
        $error("backend write request changed before it was accepted");
        fail_count++;
    end

endmodule

bind scpad_backend_top scpad_sva u_sva (
    .clk                   (clk),
    .n_rst                 (n_rst),
    .dr_complete           (dr_complete),
    .sram_write_queue_full (sram_write_queue_full),
    .be_accept             (be_accept),
    .fe_grant              (fe_grant),
    .sram_write_req        (sram_write_req)
);

// ==== sim/scpad_tb.sv ====
module scpad_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import scpad_pkg::*;

    // cycles allowed for any single wait
    localparam int    WAIT_LIMIT = 200;
    localparam int    SEED       = 39273;
    localparam string TESTS_FILE = "sim/scpad_tests.txt";

    logic                     clk;
    logic                     n_rst;
    logic                     dr_complete;
    logic [DRAM_ID_WIDTH-1:0] dram_data_id;
    layout_e                  dr_row_or_col;
    xbar_desc_t               dr_xbar;
    scpad_data_t              dr_rdata;
    logic                     sram_write_queue_full;
    logic                     fe_req;
    logic                     fe_write;
    layout_e                  fe_row_or_col;
    xbar_desc_t               fe_xbar;
    scpad_data_t              fe_wdata;
    logic                     fe_busy;
    logic                     fe_done;
    scpad_data_t              fe_rdata;

    // one parsed line of the tests file
    int          fd;
    int          fields;
    string       line;
    byte         op;
    int          id;
    int          layout;
    int          row;
    int          shift;
    logic [15:0] lane [NUM_BANKS];
    scpad_data_t word;

    tb_clock_gen clk_gen0 (.clk(clk));

    scpad_backend_top dut0 (.*);

    task automatic stop_with_failure();
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // queue space, and the id's old request must have drained
    task automatic wait_queue_space(input int qid);
        int n;
        n = 0;
        while (sram_write_queue_full || dut0.u_queue.slot_valid[qid]) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                $display("timeout waiting for write queue space for id %0d", qid);
                stop_with_failure();
            end
        end
    endtask

    task automatic wait_port_idle();
        int n;
        n = 0;
        while (fe_busy) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                $display("timeout waiting for fe_busy to fall");
                stop_with_failure();
            end
        end
    endtask

    task automatic wait_frontend_done();
        int n;
        n = 0;
        while (!fe_done) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                $display("timeout waiting for fe_done");
                stop_with_failure();
            end
        end
    endtask

    // backend queue empty and frontend port idle
    task automatic wait_drain();
        int n;
        n = 0;
        while (dut0.u_queue.sram_write_req.valid || fe_busy) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                $display("timeout waiting for the write queue to drain");
                stop_with_failure();
            end
        end
    endtask

    // single-cycle completion pulse
    task automatic send_completion(input int qid, input int lay, input int r, input int s,
                                   input scpad_data_t data);
        wait_queue_space(qid);
        dr_complete     = 1'b1;
        dram_data_id    = DRAM_ID_WIDTH'(qid);
        dr_row_or_col   = layout_e'(lay);
        dr_xbar.row     = row_addr_t'(r);
        dr_xbar.shift   = lane_shift_t'(s);
        dr_rdata        = data;
        @(negedge clk);
        dr_complete     = 1'b0;
    endtask

    // one-cycle fe_req strobe, taken while the port is idle
    task automatic start_frontend(input logic wr, input int lay, input int r, input int s,
                                  input scpad_data_t data);
        wait_port_idle();
        fe_req        = 1'b1;
        fe_write      = wr;
        fe_row_or_col = layout_e'(lay);
        fe_xbar.row   = row_addr_t'(r);
        fe_xbar.shift = lane_shift_t'(s);
        fe_wdata      = data;
        @(negedge clk);
        fe_req        = 1'b0;
    endtask

    task automatic check_read(input int lay, input int r, input int s,
                              input scpad_data_t expected);
        start_frontend(1'b0, lay, r, s, '0);
        wait_frontend_done();
        assert (fe_rdata === expected)
        else begin
            $display("MISMATCH fe_rdata row %h shift %h: got %h expected %h",
                     r, s, fe_rdata, expected);
            stop_with_failure();
        end
    endtask

    // 0 to 3 idle cycles between lines
    task automatic idle_gap();
        repeat ($urandom % 4) @(negedge clk);
    endtask

    // bound assertions are polled every cycle
    always @(negedge clk) begin
        assert (dut0.u_sva.fail_count == 0)
        else begin
            $display("a bound assertion in scpad_sva fired");
            stop_with_failure();
        end
    end

    initial begin
        n_rst         = 1'b0;
        dr_complete   = 1'b0;
        dram_data_id  = '0;
        dr_row_or_col = LAYOUT_ROW;
        dr_xbar       = '0;
        dr_rdata      = '0;
        fe_req        = 1'b0;
        fe_write      = 1'b0;
        fe_row_or_col = LAYOUT_ROW;
        fe_xbar       = '0;
        fe_wdata      = '0;
        void'($urandom(SEED));

        fd = $fopen(TESTS_FILE, "r");
        if (fd == 0) begin
            $display("could not open %s", TESTS_FILE);
            stop_with_failure();
        end

        repeat (16) @(negedge clk);
        n_rst = 1'b1;
        @(negedge clk);
        assert (!sram_write_queue_full && !fe_busy && !fe_done)
        else begin
            $display("outputs not idle after reset");
            stop_with_failure();
        end

        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) begin
                break;
            end
            // blank lines and comment lines
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%c %h %h %h %h %h %h %h %h", op, id, layout, row, shift,
                             lane[0], lane[1], lane[2], lane[3]);
            if (fields != 9) begin
                $display("malformed line in tests file: %s", line);
                stop_with_failure();
            end
            word = {lane[3], lane[2], lane[1], lane[0]};
            case (op)
                "C": send_completion(id, layout, row, shift, word);
                "W": begin
                    start_frontend(1'b1, layout, row, shift, word);
                    wait_frontend_done();
                end
                // posted write, fe_done is watched in the background
                "P": begin
                    start_frontend(1'b1, layout, row, shift, word);
                    fork
                        wait_frontend_done();
                    join_none
                end
                "R": check_read(layout, row, shift, word);
                "D": wait_drain();
                default: begin
                    $display("unknown operation in tests file: %s", line);
                    stop_with_failure();
                end
            endcase
            idle_gap();
        end
        $fclose(fd);
        wait_drain();

        if (dut0.u_sva.fail_count == 0) begin
            $display("No errors");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule

// ==== tb.f ====
src/scpad_pkg.sv
src/sram_write_request_queue.sv
src/frontend_access_port.sv
src/scpad_arbiter.sv
src/scpad_sram.sv
src/scpad_backend_top.sv
sim/tb_clock_gen.sv
sim/scpad_sva.sv
sim/scpad_tb.sv

// ==== sim/scpad_tests.txt ====
# op id layout row shift lane0 lane1 lane2 lane3 (all hex, layout 0 row 1 column)
# C completion, W frontend write, P posted frontend write, R read and expect, D drain
C 1 0 1 0 1110 1111 1112 1113
D 0 0 0 0 0000 0000 0000 0000
R 0 0 1 0 1110 1111 1112 1113
R 0 0 1 2 1112 1113 1110 1111
# column writes with all four shifts tile rows 8 to b
C 0 1 8 0 c000 c001 c002 c003
C 1 1 8 1 c010 c011 c012 c013
W 0 1 8 2 c020 c021 c022 c023
W 0 1 8 3 c030 c031 c032 c033
D 0 0 0 0 0000 0000 0000 0000
R 0 1 8 0 c000 c001 c002 c003
R 0 1 8 1 c010 c011 c012 c013
R 0 1 8 2 c020 c021 c022 c023
R 0 1 8 3 c030 c031 c032 c033
R 0 0 9 0 c031 c001 c011 c021
R 0 0 a 1 c032 c002 c012 c022
# completion order wins over id order
C 5 0 2 1 5000 5001 5002 5003
C 2 0 2 1 2000 2001 2002 2003
C 7 0 2 1 7000 7001 7002 7003
D 0 0 0 0 0000 0000 0000 0000
R 0 0 2 1 7000 7001 7002 7003
# burst of 12 completions against frontend writes
C 0 0 0 0 a000 a001 a002 a003
P 0 0 8 1 f800 f801 f802 f803
C 1 0 1 1 a100 a101 a102 a103
C 2 0 2 2 a200 a201 a202 a203
P 0 0 9 2 f900 f901 f902 f903
C 3 0 3 3 a300 a301 a302 a303
C 4 0 4 0 a400 a401 a402 a403
P 0 0 a 3 fa00 fa01 fa02 fa03
C 5 0 5 1 a500 a501 a502 a503
C 6 0 6 2 a600 a601 a602 a603
P 0 0 b 0 fb00 fb01 fb02 fb03
C 7 0 7 3 a700 a701 a702 a703
C 0 0 c 0 ac00 ac01 ac02 ac03
C 1 0 d 1 ad00 ad01 ad02 ad03
C 2 0 e 2 ae00 ae01 ae02 ae03
C 3 0 f 3 af00 af01 af02 af03
D 0 0 0 0 0000 0000 0000 0000
R 0 0 0 0 a000 a001 a002 a003
R 0 0 1 1 a100 a101 a102 a103
R 0 0 2 2 a200 a201 a202 a203
R 0 0 3 3 a300 a301 a302 a303
R 0 0 4 0 a400 a401 a402 a403
R 0 0 5 1 a500 a501 a502 a503
R 0 0 6 2 a600 a601 a602 a603
R 0 0 7 3 a700 a701 a702 a703
R 0 0 c 0 ac00 ac01 ac02 ac03
R 0 0 d 1 ad00 ad01 ad02 ad03
R 0 0 e 2 ae00 ae01 ae02 ae03
R 0 0 f 3 af00 af01 af02 af03
R 0 0 8 1 f800 f801 f802 f803
R 0 0 9 2 f900 f901 f902 f903
R 0 0 a 3 fa00 fa01 fa02 fa03
R 0 0 b 0 fb00 fb01 fb02 fb03
# frontend write then read back
W 0 0 4 3 5a00 5a01 5a02 5a03
R 0 0 4 3 5a00 5a01 5a02 5a03
R 0 0 5 1 a500 a501 a502 a503
